//--- hdl/atmega_io_pkg.sv
// ATmega I/O subsystem definitions
package atmega_io_pkg;

    localparam int IO_ADDR_W = 6;
    localparam int DATA_W    = 8;

    // I/O-space register map
    localparam logic [IO_ADDR_W-1:0] PINB_ADDR   = 6'h03;
    localparam logic [IO_ADDR_W-1:0] DDRB_ADDR   = 6'h04;
    localparam logic [IO_ADDR_W-1:0] PORTB_ADDR  = 6'h05;
    localparam logic [IO_ADDR_W-1:0] PINF_ADDR   = 6'h0F;
    localparam logic [IO_ADDR_W-1:0] DDRF_ADDR   = 6'h10;
    localparam logic [IO_ADDR_W-1:0] PORTF_ADDR  = 6'h11;
    localparam logic [IO_ADDR_W-1:0] TIFR0_ADDR  = 6'h15;
    localparam logic [IO_ADDR_W-1:0] TCCR0A_ADDR = 6'h24;
    localparam logic [IO_ADDR_W-1:0] TCCR0B_ADDR = 6'h25;
    localparam logic [IO_ADDR_W-1:0] TCNT0_ADDR  = 6'h26;
    localparam logic [IO_ADDR_W-1:0] OCR0A_ADDR  = 6'h27;
    localparam logic [IO_ADDR_W-1:0] TIMSK0_ADDR = 6'h2F; // Moved from data space

    localparam logic [DATA_W-1:0] PINMASK_B = 8'hF0;
    localparam logic [DATA_W-1:0] PINMASK_F = 8'hF3;

    localparam int PRESC_W = 10;

    localparam int TOV0_BIT  = 0;
    localparam int OCF0A_BIT = 1;
    localparam int COM0A_LSB = 6;
    localparam int WGM01_BIT = 1;
    localparam int CS0_W     = 3;

    // Implemented bits of TIFR0 and TIMSK0
    localparam logic [DATA_W-1:0] TIM_IRQ_MASK = 8'h03;

    localparam logic [CS0_W-1:0] CS_STOP    = 3'd0;
    localparam logic [CS0_W-1:0] CS_DIV1    = 3'd1;
    localparam logic [CS0_W-1:0] CS_DIV8    = 3'd2;
    localparam logic [CS0_W-1:0] CS_DIV64   = 3'd3;
    localparam logic [CS0_W-1:0] CS_DIV256  = 3'd4;
    localparam logic [CS0_W-1:0] CS_DIV1024 = 3'd5;

    localparam logic [1:0] COM_OFF    = 2'd0;
    localparam logic [1:0] COM_TOGGLE = 2'd1;
    localparam logic [1:0] COM_CLEAR  = 2'd2;
    localparam logic [1:0] COM_SET    = 2'd3;

    typedef struct packed {
        logic [IO_ADDR_W-1:0] addr;
        logic                 wr;
        logic                 rd;
        logic [DATA_W-1:0]    wdata;
    } io_req_t;

    typedef struct packed {
        logic port;
        logic ddr;
        logic pin_wr; // Toggles PORT bits
    } gpio_wr_t;

    typedef struct packed {
        logic [DATA_W-1:0] port;
        logic [DATA_W-1:0] ddr;
        logic [DATA_W-1:0] pin;
    } gpio_view_t;

    typedef struct packed {
        logic tccra;
        logic tccrb;
        logic tcnt;
        logic ocra;
        logic timsk;
        logic tifr;
    } tim_wr_t;

    typedef struct packed {
        logic [DATA_W-1:0] tccra;
        logic [DATA_W-1:0] tccrb;
        logic [DATA_W-1:0] tcnt;
        logic [DATA_W-1:0] ocra;
        logic [DATA_W-1:0] timsk;
        logic [DATA_W-1:0] tifr;
    } tim_view_t;

endpackage

//--- hdl/io_decoder.sv
// I/O bus decoder and read port
`timescale 1ns/1ps

module io_decoder
    import atmega_io_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  io_req_t           io_req,
    input  gpio_view_t        gpio_b_view,
    input  gpio_view_t        gpio_f_view,
    input  tim_view_t         tim_view,
    output logic [DATA_W-1:0] wdata,
    output gpio_wr_t          gpio_b_wr,
    output gpio_wr_t          gpio_f_wr,
    output tim_wr_t           tim_wr,
    output logic [DATA_W-1:0] io_rdata
);

    logic [DATA_W-1:0] rd_mux;

    assign wdata = io_req.wdata; // Shared by all peripherals

    // One strobe per write, none for unmapped addresses
    always_comb
    begin
        gpio_b_wr = '0;
        gpio_f_wr = '0;
        tim_wr    = '0;
        if (io_req.wr)
        begin
            case (io_req.addr)
                PINB_ADDR:   gpio_b_wr.pin_wr = 1'b1;
                DDRB_ADDR:   gpio_b_wr.ddr    = 1'b1;
                PORTB_ADDR:  gpio_b_wr.port   = 1'b1;
                PINF_ADDR:   gpio_f_wr.pin_wr = 1'b1;
                DDRF_ADDR:   gpio_f_wr.ddr    = 1'b1;
                PORTF_ADDR:  gpio_f_wr.port   = 1'b1;
                TIFR0_ADDR:  tim_wr.tifr      = 1'b1;
                TCCR0A_ADDR: tim_wr.tccra     = 1'b1;
                TCCR0B_ADDR: tim_wr.tccrb     = 1'b1;
                TCNT0_ADDR:  tim_wr.tcnt      = 1'b1;
                OCR0A_ADDR:  tim_wr.ocra      = 1'b1;
                TIMSK0_ADDR: tim_wr.timsk     = 1'b1;
                default: ;
            endcase
        end
    end

    // Read select
    always_comb
    begin
        case (io_req.addr)
            PINB_ADDR:   rd_mux = gpio_b_view.pin;
            DDRB_ADDR:   rd_mux = gpio_b_view.ddr;
            PORTB_ADDR:  rd_mux = gpio_b_view.port;
            PINF_ADDR:   rd_mux = gpio_f_view.pin;
            DDRF_ADDR:   rd_mux = gpio_f_view.ddr;
            PORTF_ADDR:  rd_mux = gpio_f_view.port;
            TIFR0_ADDR:  rd_mux = tim_view.tifr;
            TCCR0A_ADDR: rd_mux = tim_view.tccra;
            TCCR0B_ADDR: rd_mux = tim_view.tccrb;
            TCNT0_ADDR:  rd_mux = tim_view.tcnt;
            OCR0A_ADDR:  rd_mux = tim_view.ocra;
            TIMSK0_ADDR: rd_mux = tim_view.timsk;
            default:     rd_mux = '0; // Unmapped
        endcase
    end

    // Read byte holds until the next read strobe
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            io_rdata <= '0;
        end
        else if (io_req.rd)
        begin
            io_rdata <= rd_mux;
        end
    end

endmodule

//--- hdl/gpio_port.sv
// General-purpose I/O port
`timescale 1ns/1ps

module gpio_port
    import atmega_io_pkg::*;
#(
    parameter logic [DATA_W-1:0] PIN_MASK = 8'hFF
)
(
    input  logic              clk,
    input  logic              rst,
    input  gpio_wr_t          wr,
    input  logic [DATA_W-1:0] wdata,
    input  logic [DATA_W-1:0] pin_in,
    output gpio_view_t        view,
    output logic [DATA_W-1:0] pad_out,
    output logic [DATA_W-1:0] pad_oe
);

    logic [DATA_W-1:0] port_q;
    logic [DATA_W-1:0] ddr_q;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            port_q <= '0;
            ddr_q  <= '0;
        end
        else
        begin
            if (wr.port)
                port_q <= wdata & PIN_MASK;
            else if (wr.pin_wr)
                port_q <= (port_q ^ wdata) & PIN_MASK; // PIN write toggles
            if (wr.ddr)
                ddr_q <= wdata & PIN_MASK;
        end
    end

    assign pad_out = port_q;
    assign pad_oe  = ddr_q;

    // Outputs read back their own drive value
    assign view.port = port_q;
    assign view.ddr  = ddr_q;
    assign view.pin  = ((ddr_q & port_q) | (~ddr_q & pin_in)) & PIN_MASK;

endmodule

//--- hdl/tim0_prescaler.sv
// Timer0 prescaler
`timescale 1ns/1ps

module tim0_prescaler
    import atmega_io_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [CS0_W-1:0] cs,
    output logic             tick
);

    logic [PRESC_W-1:0] cnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1; // Free running
    end

    // Tick when the selected low bits are all ones
    always_comb
    begin
        case (cs)
            CS_STOP:    tick = 1'b0;
            CS_DIV1:    tick = 1'b1;
            CS_DIV8:    tick = &cnt[2:0];
            CS_DIV64:   tick = &cnt[5:0];
            CS_DIV256:  tick = &cnt[7:0];
            CS_DIV1024: tick = &cnt[PRESC_W-1:0];
            default:    tick = 1'b0; // Codes 6 and 7 stop the timer
        endcase
    end

endmodule

//--- hdl/tim0_counter.sv
// Timer/Counter0 with compare unit A
`timescale 1ns/1ps

module tim0_counter
    import atmega_io_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  tim_wr_t           wr,
    input  logic [DATA_W-1:0] wdata,
    input  logic              tick,
    output tim_view_t         view,
    output logic              oc0a,
    output logic              oc0a_en,
    output logic              irq
);

    logic [DATA_W-1:0] tccra_q;
    logic [DATA_W-1:0] tccrb_q;
    logic [DATA_W-1:0] tcnt_q;
    logic [DATA_W-1:0] ocra_q;
    logic [DATA_W-1:0] timsk_q;
    logic [DATA_W-1:0] tifr_q;
    logic [1:0]        com0a;
    logic [DATA_W-1:0] top;
    logic              cmp_hit;
    logic              ovf_hit;
    logic [DATA_W-1:0] tcnt_nxt;
    logic [DATA_W-1:0] flag_set;
    logic [DATA_W-1:0] flag_clr;
    logic              oc_nxt;

    assign com0a = tccra_q[COM0A_LSB +: 2];
    assign top   = tccra_q[WGM01_BIT] ? ocra_q : 8'hFF; // CTC or normal

    assign cmp_hit = tick && (tcnt_q == ocra_q);
    assign ovf_hit = tick && (tcnt_q == 8'hFF); // Always wraps to 0 from 0xFF

    always_comb
    begin
        tcnt_nxt = tcnt_q;
        if (wr.tcnt)
            tcnt_nxt = wdata; // Bus write beats the tick
        else if (tick)
            tcnt_nxt = (tcnt_q == top) ? '0 : tcnt_q + 1'b1;
    end

    always_comb
    begin
        flag_set = '0;
        flag_set[TOV0_BIT]  = ovf_hit;
        flag_set[OCF0A_BIT] = cmp_hit;
        flag_clr = wr.tifr ? wdata : '0; // Write one to clear
    end

    // Compare output action
    always_comb
    begin
        oc_nxt = oc0a;
        if (cmp_hit)
        begin
            case (com0a)
                COM_TOGGLE: oc_nxt = ~oc0a;
                COM_CLEAR:  oc_nxt = 1'b0;
                COM_SET:    oc_nxt = 1'b1;
                default:    oc_nxt = oc0a;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tccra_q <= '0;
            tccrb_q <= '0;
            tcnt_q  <= '0;
            ocra_q  <= '0;
            timsk_q <= '0;
            tifr_q  <= '0;
            oc0a    <= 1'b0;
        end
        else
        begin
            if (wr.tccra)
                tccra_q <= wdata;
            if (wr.tccrb)
                tccrb_q <= wdata;
            if (wr.ocra)
                ocra_q <= wdata;
            if (wr.timsk)
                timsk_q <= wdata & TIM_IRQ_MASK;
            tcnt_q <= tcnt_nxt;
            tifr_q <= (tifr_q | flag_set) & ~flag_clr & TIM_IRQ_MASK; // Clear wins
            oc0a   <= oc_nxt;
        end
    end

    assign oc0a_en = (com0a != COM_OFF);
    assign irq     = |(tifr_q & timsk_q);

    assign view.tccra = tccra_q;
    assign view.tccrb = tccrb_q;
    assign view.tcnt  = tcnt_q;
    assign view.ocra  = ocra_q;
    assign view.timsk = timsk_q;
    assign view.tifr  = tifr_q;

endmodule

//--- hdl/atmega_io_top.sv
// ATmega32U4 I/O subsystem top
`timescale 1ns/1ps

module atmega_io_top
    import atmega_io_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  io_req_t           io_req,
    input  logic [DATA_W-1:0] pb_in,
    input  logic [DATA_W-1:0] pf_in,
    output logic [DATA_W-1:0] io_rdata,
    output logic [DATA_W-1:0] pb_out,
    output logic [DATA_W-1:0] pb_oe,
    output logic [DATA_W-1:0] pf_out,
    output logic [DATA_W-1:0] pf_oe,
    output logic              oc0a,
    output logic              oc0a_en,
    output logic              tim0_irq
);

    logic [DATA_W-1:0] wdata;
    gpio_wr_t          gpio_b_wr;
    gpio_wr_t          gpio_f_wr;
    tim_wr_t           tim_wr;
    gpio_view_t        gpio_b_view;
    gpio_view_t        gpio_f_view;
    tim_view_t         tim_view;
    logic              tick;

    io_decoder u_decoder (
        .clk         (clk),
        .rst         (rst),
        .io_req      (io_req),
        .gpio_b_view (gpio_b_view),
        .gpio_f_view (gpio_f_view),
        .tim_view    (tim_view),
        .wdata       (wdata),
        .gpio_b_wr   (gpio_b_wr),
        .gpio_f_wr   (gpio_f_wr),
        .tim_wr      (tim_wr),
        .io_rdata    (io_rdata)
    );

    gpio_port #(.PIN_MASK(PINMASK_B)) u_port_b (
        .clk     (clk),
        .rst     (rst),
        .wr      (gpio_b_wr),
        .wdata   (wdata),
        .pin_in  (pb_in),
        .view    (gpio_b_view),
        .pad_out (pb_out),
        .pad_oe  (pb_oe)
    );

    gpio_port #(.PIN_MASK(PINMASK_F)) u_port_f (
        .clk     (clk),
        .rst     (rst),
        .wr      (gpio_f_wr),
        .wdata   (wdata),
        .pin_in  (pf_in),
        .view    (gpio_f_view),
        .pad_out (pf_out),
        .pad_oe  (pf_oe)
    );

    // Clock select lives in TCCR0B bits 2..0
    tim0_prescaler u_presc (
        .clk  (clk),
        .rst  (rst),
        .cs   (tim_view.tccrb[CS0_W-1:0]),
        .tick (tick)
    );

    tim0_counter u_tim0 (
        .clk     (clk),
        .rst     (rst),
        .wr      (tim_wr),
        .wdata   (wdata),
        .tick    (tick),
        .view    (tim_view),
        .oc0a    (oc0a),
        .oc0a_en (oc0a_en),
        .irq     (tim0_irq)
    );

endmodule

//--- tb/atmega_io_top_sva.sv
// Bus and interrupt assertions
`timescale 1ns/1ps

module atmega_io_top_sva
    import atmega_io_pkg::*;
(
    input logic              clk,
    input logic              rst,
    input io_req_t           io_req,
    input gpio_wr_t          gpio_b_wr,
    input gpio_wr_t          gpio_f_wr,
    input tim_wr_t           tim_wr,
    input tim_view_t         tim_view,
    input logic [DATA_W-1:0] io_rdata,
    input logic              tim0_irq
);

    // At most one register strobe per access
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({gpio_b_wr, gpio_f_wr, tim_wr}))
    else
        $error("more than one register write strobe active");

    assert property (@(posedge clk) disable iff (rst) !io_req.rd |=> $stable(io_rdata))
    else
        $error("io_rdata changed without a read strobe");

    assert property (@(posedge clk) disable iff (rst)
        tim0_irq == |(tim_view.tifr & tim_view.timsk))
    else
        $error("tim0_irq differs from flags and mask");

endmodule

// Sees the decoder strobes and the timer view in one place
bind atmega_io_top atmega_io_top_sva u_sva (
    .clk       (clk),
    .rst       (rst),
    .io_req    (io_req),
    .gpio_b_wr (gpio_b_wr),
    .gpio_f_wr (gpio_f_wr),
    .tim_wr    (tim_wr),
    .tim_view  (tim_view),
    .io_rdata  (io_rdata),
    .tim0_irq  (tim0_irq)
);

//--- tb/atmega_io_top_tb.sv
// ATmega I/O subsystem testbench
`timescale 1ns/1ps

module atmega_io_top_tb
    import atmega_io_pkg::*;
();

    localparam int NORMAL_CYC  = 3 * 5 * (1 + 8 + 64 + 256 + 1024) + 8 * 80;
    localparam int CTC_CYC     = 12 * (2 * 257 * 8 + 8);
    localparam int PLAN_CYC    = 5 + 600 + 200 + NORMAL_CYC + CTC_CYC + 300 * 3 + 16;
    localparam int WATCHDOG_NS = PLAN_CYC * 10 + 10000;
    localparam logic [DATA_W-1:0] FLAG_BITS = (1 << TOV0_BIT) | (1 << OCF0A_BIT);

    logic              clk;
    logic              rst;
    io_req_t           io_req;
    logic [DATA_W-1:0] pb_in;
    logic [DATA_W-1:0] pf_in;
    logic [DATA_W-1:0] io_rdata;
    logic [DATA_W-1:0] pb_out;
    logic [DATA_W-1:0] pb_oe;
    logic [DATA_W-1:0] pf_out;
    logic [DATA_W-1:0] pf_oe;
    logic              oc0a;
    logic              oc0a_en;
    logic              tim0_irq;

    integer seed;
    int     errors;
    int     checks;
    logic [IO_ADDR_W-1:0] port_addrs [0:5] = '{PINB_ADDR, DDRB_ADDR, PORTB_ADDR,
                                               PINF_ADDR, DDRF_ADDR, PORTF_ADDR};

    // Reference model, registers indexed by I/O address
    logic [DATA_W-1:0]  m_reg [0:2**IO_ADDR_W-1];
    logic [DATA_W-1:0]  m_rdata;
    logic               m_oc0a;
    logic [PRESC_W-1:0] m_presc;

    atmega_io_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .io_req   (io_req),
        .pb_in    (pb_in),
        .pf_in    (pf_in),
        .io_rdata (io_rdata),
        .pb_out   (pb_out),
        .pb_oe    (pb_oe),
        .pf_out   (pf_out),
        .pf_oe    (pf_oe),
        .oc0a     (oc0a),
        .oc0a_en  (oc0a_en),
        .tim0_irq (tim0_irq)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int tap_bits(input logic [CS0_W-1:0] cs);
        case (cs)
            CS_DIV8:    return 3;
            CS_DIV64:   return 6;
            CS_DIV256:  return 8;
            CS_DIV1024: return 10;
            default:    return 0;
        endcase
    endfunction

    function automatic logic [PRESC_W-1:0] tap_mask(input logic [CS0_W-1:0] cs);
        return (PRESC_W'(1) << tap_bits(cs)) - 1'b1;
    endfunction

    function automatic bit is_mapped(input logic [IO_ADDR_W-1:0] addr);
        return addr inside {PINB_ADDR, DDRB_ADDR, PORTB_ADDR, PINF_ADDR, DDRF_ADDR,
                            PORTF_ADDR, TIFR0_ADDR, TCCR0A_ADDR, TCCR0B_ADDR,
                            TCNT0_ADDR, OCR0A_ADDR, TIMSK0_ADDR};
    endfunction

    // Driven bits read back PORT, inputs read the pad
    function automatic logic [DATA_W-1:0] pin_view(input logic [DATA_W-1:0] ddr, port,
                                                   pins, mask);
        logic [DATA_W-1:0] v;
        v = '0;
        for (int i = 0; i < DATA_W; i++)
        begin
            if (mask[i])
                v[i] = ddr[i] ? port[i] : pins[i];
        end
        return v;
    endfunction

    task automatic reset_model();
        foreach (m_reg[i])
            m_reg[i] = '0;
        m_rdata = '0;
        m_oc0a  = 1'b0;
        m_presc = '0;
    endtask

    task automatic step_model();
        logic [DATA_W-1:0] nxt [0:2**IO_ADDR_W-1];
        logic [DATA_W-1:0] rd_val;
        logic [DATA_W-1:0] tcnt;
        logic [DATA_W-1:0] top;
        logic [DATA_W-1:0] clr;
        logic [CS0_W-1:0]  cs;
        logic              tick;
        logic              cmp;
        nxt  = m_reg;
        tcnt = m_reg[TCNT0_ADDR];
        cs   = m_reg[TCCR0B_ADDR][CS0_W-1:0];
        tick = (cs >= CS_DIV1 && cs <= CS_DIV1024) && ((m_presc & tap_mask(cs)) == tap_mask(cs));
        top  = m_reg[TCCR0A_ADDR][WGM01_BIT] ? m_reg[OCR0A_ADDR] : 8'hFF;
        cmp  = tick && (tcnt == m_reg[OCR0A_ADDR]);
        clr  = '0;
        case (io_req.addr)
            PINB_ADDR: rd_val = pin_view(m_reg[DDRB_ADDR], m_reg[PORTB_ADDR], pb_in, PINMASK_B);
            PINF_ADDR: rd_val = pin_view(m_reg[DDRF_ADDR], m_reg[PORTF_ADDR], pf_in, PINMASK_F);
            default:   rd_val = is_mapped(io_req.addr) ? m_reg[io_req.addr] : 8'h00;
        endcase
        if (io_req.wr)
        begin
            case (io_req.addr)
                PINB_ADDR:
                    nxt[PORTB_ADDR] = (m_reg[PORTB_ADDR] ^ io_req.wdata) & PINMASK_B;
                PINF_ADDR:
                    nxt[PORTF_ADDR] = (m_reg[PORTF_ADDR] ^ io_req.wdata) & PINMASK_F;
                PORTB_ADDR, DDRB_ADDR: nxt[io_req.addr] = io_req.wdata & PINMASK_B;
                PORTF_ADDR, DDRF_ADDR: nxt[io_req.addr] = io_req.wdata & PINMASK_F;
                TIMSK0_ADDR: nxt[TIMSK0_ADDR] = io_req.wdata & FLAG_BITS;
                TIFR0_ADDR:  clr = io_req.wdata; // Write one to clear
                TCCR0A_ADDR, TCCR0B_ADDR, TCNT0_ADDR, OCR0A_ADDR:
                    nxt[io_req.addr] = io_req.wdata;
                default: ;
            endcase
        end
        if (tick && !(io_req.wr && io_req.addr == TCNT0_ADDR))
            nxt[TCNT0_ADDR] = (tcnt == top) ? 8'h00 : tcnt + 8'h01;
        nxt[TIFR0_ADDR] = m_reg[TIFR0_ADDR];
        if (tick && tcnt == 8'hFF)
            nxt[TIFR0_ADDR][TOV0_BIT] = 1'b1;
        if (cmp)
            nxt[TIFR0_ADDR][OCF0A_BIT] = 1'b1;
        nxt[TIFR0_ADDR] = nxt[TIFR0_ADDR] & ~clr & FLAG_BITS; // Clear beats set
        if (cmp)
        begin
            case (m_reg[TCCR0A_ADDR][COM0A_LSB +: 2])
                COM_TOGGLE: m_oc0a = ~m_oc0a;
                COM_CLEAR:  m_oc0a = 1'b0;
                COM_SET:    m_oc0a = 1'b1;
                default: ;
            endcase
        end
        if (io_req.rd)
            m_rdata = rd_val;
        m_presc = m_presc + 1'b1;
        m_reg   = nxt;
    endtask

    always @(posedge clk)
    begin
        if (rst)
            reset_model();
        else
            step_model();
    end

    task automatic compare_byte(input string name, input logic [DATA_W-1:0] got,
                                input logic [DATA_W-1:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk)
    begin
        if (rst === 1'b0)
        begin
            compare_byte("io_rdata", io_rdata, m_rdata);
            compare_byte("pb_out", pb_out, m_reg[PORTB_ADDR]);
            compare_byte("pb_oe", pb_oe, m_reg[DDRB_ADDR]);
            compare_byte("pf_out", pf_out, m_reg[PORTF_ADDR]);
            compare_byte("pf_oe", pf_oe, m_reg[DDRF_ADDR]);
            compare_byte("oc0a", oc0a, m_oc0a);
            compare_byte("oc0a_en", oc0a_en, m_reg[TCCR0A_ADDR][COM0A_LSB +: 2] != COM_OFF);
            compare_byte("tim0_irq", tim0_irq, |(m_reg[TIFR0_ADDR] & m_reg[TIMSK0_ADDR]));
        end
    end

    task automatic drive_bus(input logic [IO_ADDR_W-1:0] addr, input logic wr, input logic rd,
                             input logic [DATA_W-1:0] data);
        @(posedge clk);
        io_req <= '{addr: addr, wr: wr, rd: rd, wdata: data};
        pb_in  <= DATA_W'($random(seed));
        pf_in  <= DATA_W'($random(seed));
    endtask

    task automatic write_reg(input logic [IO_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        drive_bus(addr, 1'b1, 1'b0, data);
    endtask

    task automatic read_reg(input logic [IO_ADDR_W-1:0] addr);
        drive_bus(addr, 1'b0, 1'b1, DATA_W'($random(seed)));
    endtask

    task automatic poll_timer(input int n);
        logic [31:0] r;
        repeat (n)
        begin
            r = $random(seed);
            read_reg(r[0] ? TCNT0_ADDR : TIFR0_ADDR);
        end
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        logic [31:0]          r;
        logic [DATA_W-1:0]    ocr;
        logic [CS0_W-1:0]     cs;
        int                   period;
        seed   = 32'haf90_c87a;
        errors = 0;
        checks = 0;
        rst    = 1'b1;
        io_req = '0;
        pb_in  = '0;
        pf_in  = '0;
        reset_model();
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // GPIO registers with random pads
        repeat (600)
        begin
            r = $random(seed);
            drive_bus(port_addrs[r[10:8] % 6], r[1:0] == 2'd0, r[1:0] inside {2'd1, 2'd2},
                      r[31:24]);
        end

        // Unmapped space, mixed with mapped read-back
        repeat (200)
        begin
            r = $random(seed);
            while (is_mapped(r[5:0]))
                r = $random(seed);
            if (r[7:6] == 2'd0)
                read_reg(port_addrs[r[10:8] % 6]);
            else
                drive_bus(r[5:0], r[8], !r[8], r[31:24]);
        end

        // Normal mode, every clock select
        write_reg(TCCR0A_ADDR, 8'h00);
        for (int c = 0; c < 8; c++)
        begin
            cs = CS0_W'(c);
            write_reg(TCCR0B_ADDR, DATA_W'(cs));
            period = (cs >= CS_DIV1 && cs <= CS_DIV1024) ? (1 << tap_bits(cs)) : 4;
            repeat (3)
            begin
                r = $random(seed);
                write_reg(TCNT0_ADDR, r[8] ? (8'hFC | r[1:0]) : r[7:0]); // Near wrap half the time
                poll_timer(5 * period + 16);
            end
            write_reg(TIFR0_ADDR, 8'hFF);
        end

        // Clear-on-compare with each COM0A action
        repeat (12)
        begin
            r   = $random(seed);
            ocr = r[7:0];
            cs  = r[10] ? CS_DIV8 : CS_DIV1;
            period = 1 << tap_bits(cs);
            write_reg(OCR0A_ADDR, ocr);
            write_reg(TCCR0A_ADDR, (DATA_W'(r[9:8]) << COM0A_LSB) | (8'h01 << WGM01_BIT));
            write_reg(TCCR0B_ADDR, DATA_W'(cs));
            write_reg(TCNT0_ADDR, r[11] ? r[23:16] : 8'h00);
            poll_timer(2 * (ocr + 2) * period);
        end
        write_reg(TIFR0_ADDR, 8'hFF);

        // Flags, mask and same-cycle set and clear
        write_reg(TCCR0A_ADDR, 8'h00);
        write_reg(TCCR0B_ADDR, DATA_W'(CS_DIV1));
        repeat (300)
        begin
            r = $random(seed);
            case (r[2:0])
                3'd0: write_reg(TIMSK0_ADDR, r[15:8]);
                3'd1: write_reg(TIFR0_ADDR, r[15:8]);
                3'd2:
                begin
                    write_reg(TCNT0_ADDR, 8'hFF);
                    write_reg(TIFR0_ADDR, r[15:8] | 8'h01); // Lands on the overflow edge
                end
                3'd3:
                begin
                    write_reg(OCR0A_ADDR, r[23:16]);
                    write_reg(TCNT0_ADDR, r[23:16]);
                    write_reg(TIFR0_ADDR, r[15:8] | 8'h02);
                end
                3'd4, 3'd5: read_reg(TIFR0_ADDR);
                3'd6: read_reg(TIMSK0_ADDR);
                default: read_reg(TCNT0_ADDR);
            endcase
        end

        repeat (3) drive_bus(6'h00, 1'b0, 1'b0, 8'h00);
        @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- atmega_io_top.f
hdl/atmega_io_pkg.sv
hdl/io_decoder.sv
hdl/gpio_port.sv
hdl/tim0_prescaler.sv
hdl/tim0_counter.sv
hdl/atmega_io_top.sv
tb/atmega_io_top_sva.sv
tb/atmega_io_top_tb.sv

//--- Bender.yml
package:
  name: atmega_io

sources:
  - hdl/atmega_io_pkg.sv
  - hdl/io_decoder.sv
  - hdl/gpio_port.sv
  - hdl/tim0_prescaler.sv
  - hdl/tim0_counter.sv
  - hdl/atmega_io_top.sv
  - target: test
    files:
      - tb/atmega_io_top_sva.sv
      - tb/atmega_io_top_tb.sv
